/* vlog.f */
+incdir+.
usiBusPkg.sv
usiCsrPkg.sv
usiIf.sv
ultraSimpleInterface.sv
usiGpioCsr.sv
usiPwmCsr.sv
usiPeriphTop.sv
tbUsiChecker.sv
tbUsiPeriphTop.sv

/* runSim.sh */
#!/bin/sh
# Verilator build and run of the USI peripheral testbench
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tbUsiPeriphTop -f vlog.f -o tbSim \
	&& ./obj_dir/tbSim | tee /dev/stderr | grep -q "^>>> PASS$" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tbUsiPeriphTop.sv */
`timescale 1ns/10ps
`default_nettype none

`include "usiBus_macros.svh"

module tbUsiPeriphTop;
	import usiBusPkg::*;

	localparam int NROW = 15;
	localparam int PWM_P = 12;                      // Period programmed
	localparam int PWM_D = 5;                       // Duty programmed
	localparam int TIMEOUT = NROW * 40 + PWM_P * 3;
	localparam int VD_WAIT = PWM_P * 3;             // Reload waits one period at most
	localparam logic [1:0] OP_WR = 2'd0;
	localparam logic [1:0] OP_RD = 2'd1;
	localparam logic [1:0] OP_MEAS = 2'd2;          // Count pwmOut highs

	logic iUsiClk;
	logic rst;
	usiData busWd;
	usiAdrs busAdrs;
	logic busWCke;
	usiData gpioIn;
	usiData busRd;
	usiVd busVd;
	usiData gpioOut;
	logic pwmOut;

	// Stimulus table
	logic [1:0] tOp [NROW];
	usiAdrs tAdrs [NROW];
	usiData tData [NROW];                           // Write data or window length
	usiData tExp [NROW];
	logic [8*20-1:0] tLabel [NROW];
	int nRow = 0;

	// Row handed to the checker
	logic chkReq, measOn;
	logic [1:0] rowOp;
	usiAdrs rowAdrs;
	usiData rowExp;
	logic [8*20-1:0] rowLabel;

	int passCnt, errCnt;
	int vdErr = 0;
	int cycleCnt = 0;
	usiData gpioVal, outVal;

	initial iUsiClk = 1'b0;
	always #50 iUsiClk = ~iUsiClk;

	usiPeriphTop dut (
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.usiWd   (busWd),
		.usiAdrs (busAdrs),
		.usiWCke (busWCke),
		.gpioIn  (gpioIn),
		.usiRd   (busRd),
		.usiVd   (busVd),
		.gpioOut (gpioOut),
		.pwmOut  (pwmOut)
	);

	tbUsiChecker chk (
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.busRd   (busRd),
		.busVd   (busVd),
		.gpioOut (gpioOut),
		.pwmOut  (pwmOut),
		.chkReq  (chkReq),
		.measOn  (measOn),
		.rowOp   (rowOp),
		.rowAdrs (rowAdrs),
		.rowExp  (rowExp),
		.rowLabel(rowLabel),
		.passCnt (passCnt),
		.errCnt  (errCnt)
	);

	// Hard stop
	always @(posedge iUsiClk)
	begin
		cycleCnt <= cycleCnt + 1;
		if (cycleCnt >= TIMEOUT)
		begin
			$display("Run stopped: no result after %0d cycles", TIMEOUT);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic void addRow(input logic [1:0] op, input usiAdrs a, input usiData d,
		input usiData e, input logic [8*20-1:0] lbl);
		tOp[nRow] = op;
		tAdrs[nRow] = a;
		tData[nRow] = d;
		tExp[nRow] = e;
		tLabel[nRow] = lbl;
		nRow++;
	endfunction

	// Ends on a posedge whose pre-edge ready bit was high
	task automatic waitSlotReady(input int slot, input logic [8*20-1:0] lbl);
		int n;
		n = 0;
		@(posedge iUsiClk);
		while (!busVd[slot] && (n < VD_WAIT))
		begin
			n++;
			@(posedge iUsiClk);
		end
		if (!busVd[slot])
		begin
			vdErr++;
			$display("%0s: ready bit of slot %0d never came up within %0d cycles",
				lbl, slot, VD_WAIT);
		end
	endtask

	task automatic flagCheck(input int r);
		rowOp <= tOp[r];
		rowAdrs <= tAdrs[r];
		rowExp <= tExp[r];
		rowLabel <= tLabel[r];
		chkReq <= 1'b1;
		@(posedge iUsiClk);
		chkReq <= 1'b0;
	endtask

	// -------------------------------------------------------------------------
	// Row drivers
	// -------------------------------------------------------------------------
	task automatic writeRow(input int r);
		int slot;
		slot = int'(tAdrs[r][15:8]) - 1;        // Slot = block - 1
		waitSlotReady(slot, tLabel[r]);
		busAdrs <= tAdrs[r];
		busWd <= tData[r];
		busWCke <= 1'b1;
		@(posedge iUsiClk);
		busWCke <= 1'b0;
		repeat (3) @(posedge iUsiClk);          // Past any stale ready bit
		waitSlotReady(slot, tLabel[r]);         // PWM drops ready until reload
		flagCheck(r);
	endtask

	task automatic readRow(input int r);
		@(posedge iUsiClk);
		busAdrs <= tAdrs[r];
		repeat (3) @(posedge iUsiClk);          // 3 cycle read path
		flagCheck(r);                           // Sampled in the 4th cycle
	endtask

	task automatic measurePwm(input int r);
		@(posedge iUsiClk);
		measOn <= 1'b1;
		repeat (int'(tData[r])) @(posedge iUsiClk);
		measOn <= 1'b0;
		flagCheck(r);
	endtask

	initial
	begin
		void'($urandom(32'he11077d9));
		gpioVal = $urandom;
		outVal = $urandom;
		rst = 1'b1;
		busWd = '0;
		busAdrs = '0;
		busWCke = 1'b0;
		gpioIn = gpioVal;                       // Held for the whole run
		chkReq = 1'b0;
		measOn = 1'b0;
		rowOp = OP_RD;
		rowAdrs = '0;
		rowExp = '0;
		rowLabel = '0;

		// PWM write rows expect the PWM ready bit back high
		addRow(OP_WR, 16'h0100, outVal, outVal, "gpio out write");
		addRow(OP_RD, 16'h0100, '0, outVal, "gpio out readback");
		addRow(OP_RD, 16'h0108, '0, 32'h6B10_0001, "gpio id");
		addRow(OP_RD, 16'h0104, '0, gpioVal, "gpio in");
		addRow(OP_RD, 16'h0000, '0, 32'h1234_5678, "block 0 unmapped");
		addRow(OP_RD, 16'h0300, '0, 32'h1234_5678, "block 3 unmapped");
		addRow(OP_RD, 16'h010C, '0, 32'h0, "gpio unused offset");
		addRow(OP_WR, 16'h0200, PWM_P, 32'd1, "pwm period write");
		addRow(OP_WR, 16'h0204, PWM_D, 32'd1, "pwm duty write");
		addRow(OP_WR, 16'h0208, 32'd1, 32'd1, "pwm enable write");
		addRow(OP_RD, 16'h0200, '0, PWM_P, "pwm period read");
		addRow(OP_RD, 16'h0204, '0, PWM_D, "pwm duty read");
		addRow(OP_MEAS, 16'h0000, PWM_P, PWM_D, "pwm high count");
		addRow(OP_WR, 16'h0208, 32'd0, 32'd1, "pwm disable write");
		addRow(OP_MEAS, 16'h0000, 2 * PWM_P, 32'd0, "pwm off 2 periods");

		repeat (3) @(posedge iUsiClk);
		rst <= 1'b0;
		repeat (4) @(posedge iUsiClk);          // Reset state check meanwhile

		for (int r = 0; r < nRow; r++)
		begin
			case (tOp[r])
				OP_WR:   writeRow(r);
				OP_RD:   readRow(r);
				default: measurePwm(r);
			endcase
		end

		@(posedge iUsiClk);
		$display("tests %0d, passed %0d, failed %0d, ready timeouts %0d",
			nRow + 1, passCnt, errCnt, vdErr);
		if ((errCnt == 0) && (vdErr == 0))
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* tbUsiChecker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "usiBus_macros.svh"

module tbUsiChecker (
	input wire iUsiClk,
	input wire rst,
	input wire usiBusPkg::usiData busRd,
	input wire usiBusPkg::usiVd busVd,
	input wire usiBusPkg::usiData gpioOut,
	input wire pwmOut,
	input wire chkReq,                  // Last cycle of a row
	input wire measOn,                  // PWM window open
	input wire [1:0] rowOp,
	input wire usiBusPkg::usiAdrs rowAdrs,
	input wire usiBusPkg::usiData rowExp,
	input wire [8*20-1:0] rowLabel,
	output int passCnt,
	output int errCnt
);
	import usiBusPkg::*;

	localparam logic [1:0] OP_RD = 2'd1;
	localparam logic [1:0] OP_MEAS = 2'd2;

	int nPass = 0;
	int nErr = 0;
	int rstAge = 3;         // Negedges since reset release, 3 = idle
	int hiCnt = 0;          // PWM high cycles in window
	int slot;
	logic rstOk;
	usiData got;

	assign passCnt = nPass;
	assign errCnt = nErr;

	// Mid cycle, all DUT outputs settled
	always @(negedge iUsiClk)
	begin
		// -------------------------------------------------------------------------
		// Reset values, then ready bits up within 2 cycles
		// -------------------------------------------------------------------------
		if (rst)
			rstAge = 0;
		else if (rstAge < 3)
		begin
			if (rstAge == 0)
			begin
				rstOk = (busRd == '0) && (gpioOut == '0) && !pwmOut && (busVd == '0);
				if (!rstOk)
				begin
					nErr++;
					$display("** Error @ %0t: reset usiRd=%h gpioOut=%h pwmOut=%b usiVd=%b",
						$time, busRd, gpioOut, pwmOut, busVd);
				end
			end
			if (rstAge == 2)
			begin
				if (busVd != '1)
				begin
					nErr++;
					$display("** Error @ %0t: usiVd=%b, expected all ones 2 cycles after reset",
						$time, busVd);
				end
				else if (rstOk)
				begin
					nPass++;
					$display("reset state: ok");
				end
			end
			rstAge++;
		end

		if (measOn)
			hiCnt = hiCnt + (pwmOut ? 1 : 0);

		// Row under test
		if (chkReq)
		begin
			case (rowOp)
				OP_RD:   got = busRd;
				OP_MEAS: got = usiData'(hiCnt);
				default:
				begin
					if (rowAdrs == {`USI_GPIO_MAP, 8'h00})
						got = gpioOut;      // GPIO OUT has a pin
					else
					begin
						slot = int'(rowAdrs[`USI_ADRS_BIT-1 -: `USI_BLOCK_BIT]) - 1;
						got = usiData'(busVd[slot]);    // Ready again after the write
					end
				end
			endcase
			if (got !== rowExp)
			begin
				nErr++;
				$display("** Error @ %0t: %0s got 0x%08h, expected 0x%08h",
					$time, rowLabel, got, rowExp);
			end
			else
			begin
				nPass++;
				$display("%0s: ok", rowLabel);
			end
			hiCnt = 0;      // Fresh window next time
		end
	end

endmodule

`default_nettype wire

/* usiPeriphTop.sv */
`timescale 1ns/10ps
`default_nettype none

`include "usiBus_macros.svh"

// ---------------------------------------------------------------------------
// Master port, bus stage, GPIO and PWM slaves
// ---------------------------------------------------------------------------
module usiPeriphTop (
	input wire iUsiClk,
	input wire rst,
	input wire usiBusPkg::usiData usiWd,
	input wire usiBusPkg::usiAdrs usiAdrs,
	input wire usiWCke,
	input wire usiBusPkg::usiData gpioIn,
	output wire usiBusPkg::usiData usiRd,
	output wire usiBusPkg::usiVd usiVd,
	output wire usiBusPkg::usiData gpioOut,
	output wire pwmOut
);

	// One channel per slot
	usiIf usiCh [`USI_SLAVE_NUM] ();

	ultraSimpleInterface uBus (
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.mWd     (usiWd),
		.mAdrs   (usiAdrs),
		.mWCke   (usiWCke),
		.mRd     (usiRd),
		.mVd     (usiVd),
		.slv     (usiCh)
	);

	// Slot = block - 1
	usiGpioCsr #(
		.pBlock (`USI_GPIO_MAP)
	) uGpio (
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.gpioIn  (gpioIn),
		.gpioOut (gpioOut),
		.usi     (usiCh[`USI_GPIO_MAP-1])
	);

	usiPwmCsr #(
		.pBlock (`USI_PWM_MAP)
	) uPwm (
		.iUsiClk (iUsiClk),
		.rst     (rst),
		.pwmOut  (pwmOut),
		.usi     (usiCh[`USI_PWM_MAP-1])
	);

endmodule

`default_nettype wire

/* usiPwmCsr.sv */
`timescale 1ns/10ps
`default_nettype none

`include "usiBus_macros.svh"

module usiPwmCsr #(
	parameter usiBusPkg::usiBlock pBlock = `USI_PWM_MAP
)(
	input wire iUsiClk,
	input wire rst,
	output logic pwmOut,
	usiIf.slave usi
);
	import usiBusPkg::*;
	import usiCsrPkg::*;

	pwmState state;
	pwmCount shPeriod, shDuty;      // Written by the bus
	pwmCount actPeriod, actDuty;    // Used by the counter
	pwmCount cnt;
	logic shEn, actEn;
	logic pending;                  // Shadow newer than active
	logic rReady, slvVd;
	logic wHit, shWr, cntWrap;
	usiBlock blk;
	usiCsrAdrs ofs;

	assign blk = usi.adrs[`USI_ADRS_BIT-1 -: `USI_BLOCK_BIT];
	assign ofs = usi.adrs[`USI_ADRS_BIT-`USI_BLOCK_BIT-1:0];
	assign slvVd = rReady && !pending;    // Busy until reload done
	assign usi.vd = slvVd;
	assign wHit = usi.wCke && (blk == pBlock) && slvVd;
	assign shWr = wHit && ((ofs == PWM_PERIOD_OFS) || (ofs == PWM_DUTY_OFS)
		|| (ofs == PWM_EN_OFS));
	assign cntWrap = (cnt >= actPeriod - 16'd1);    // Last count of period

	// ---------------------------------------------------------------------------
	// Shadow registers and reload request
	// ---------------------------------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
		begin
			shPeriod <= '0;
			shDuty <= '0;
			shEn <= 1'b0;
			rReady <= 1'b0;
			pending <= 1'b0;
		end
		else
		begin
			rReady <= 1'b1;
			if (wHit && (ofs == PWM_PERIOD_OFS)) shPeriod <= usi.wd[15:0];
			if (wHit && (ofs == PWM_DUTY_OFS))   shDuty <= usi.wd[15:0];
			if (wHit && (ofs == PWM_EN_OFS))     shEn <= usi.wd[0];
			if (state == PWM_RELOAD)
				pending <= 1'b0;    // Copied this cycle
			else if (shWr)
				pending <= 1'b1;
		end
	end

	// ---------------------------------------------------------------------------
	// Counter FSM
	// ---------------------------------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
		begin
			state <= PWM_IDLE;
			cnt <= '0;
			actPeriod <= '0;
			actDuty <= '0;
			actEn <= 1'b0;
			pwmOut <= 1'b0;
		end
		else
		begin
			pwmOut <= (state == PWM_RUN) && actEn && (cnt < actDuty);
			case (state)
				PWM_IDLE:
				begin
					cnt <= '0;
					if (pending) state <= PWM_RELOAD;   // Load at once when stopped
				end
				PWM_RUN:
				begin
					if (cntWrap)
					begin
						cnt <= '0;
						if (pending) state <= PWM_RELOAD;   // Only at period end
					end
					else
						cnt <= cnt + 16'd1;
				end
				PWM_RELOAD:
				begin
					actPeriod <= shPeriod;
					actDuty <= shDuty;
					actEn <= shEn;
					cnt <= '0;
					state <= shEn ? PWM_RUN : PWM_IDLE;
				end
				default: state <= PWM_IDLE;
			endcase
		end
	end

	// Read word, active values and live count
	always_ff @(posedge iUsiClk)
	begin
		case (ofs)
			PWM_PERIOD_OFS: usi.rd <= usiData'(actPeriod);
			PWM_DUTY_OFS:   usi.rd <= usiData'(actDuty);
			PWM_EN_OFS:     usi.rd <= usiData'(actEn);
			PWM_CNT_OFS:    usi.rd <= usiData'(cnt);
			default:        usi.rd <= '0;
		endcase
	end

	// Pin low in every cycle the block is disabled, reload cycle included
	aOffLow : assert property (@(posedge iUsiClk) disable iff (rst) !actEn |-> !pwmOut)
		else $error("pwmOut high while PWM disabled");

endmodule

`default_nettype wire

/* usiGpioCsr.sv */
`timescale 1ns/10ps
`default_nettype none

`include "usiBus_macros.svh"

module usiGpioCsr #(
	parameter usiBusPkg::usiBlock pBlock = `USI_GPIO_MAP
)(
	input wire iUsiClk,
	input wire rst,
	input wire usiBusPkg::usiData gpioIn,
	output usiBusPkg::usiData gpioOut,
	usiIf.slave usi
);
	import usiBusPkg::*;
	import usiCsrPkg::*;

	usiBlock blk;
	usiCsrAdrs ofs;
	logic rReady;
	logic wHit;
	usiData inMeta;     // First sync stage
	usiData inSync;     // Safe to read

	assign blk = usi.adrs[`USI_ADRS_BIT-1 -: `USI_BLOCK_BIT];
	assign ofs = usi.adrs[`USI_ADRS_BIT-`USI_BLOCK_BIT-1:0];
	assign usi.vd = rReady;     // Never busy
	assign wHit = usi.wCke && (blk == pBlock) && rReady;

	// Ready one cycle out of reset
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
			rReady <= 1'b0;
		else
			rReady <= 1'b1;
	end

	// ---------------------------------------------------------------------------
	// Output register and input sync
	// ---------------------------------------------------------------------------
	always_ff @(posedge iUsiClk)
	begin
		if (rst)
			gpioOut <= '0;
		else if (wHit && (ofs == GPIO_OUT_OFS))
			gpioOut <= usi.wd;
	end

	// Pins are asynchronous to the bus clock
	always_ff @(posedge iUsiClk)
	begin
		inMeta <= gpioIn;
		inSync <= inMeta;
	end

	// Read word from registered offset
	always_ff @(posedge iUsiClk)
	begin
		case (ofs)
			GPIO_OUT_OFS: usi.rd <= gpioOut;
			GPIO_IN_OFS:  usi.rd <= inSync;
			GPIO_ID_OFS:  usi.rd <= GPIO_ID_WORD;
			default:      usi.rd <= '0;     // Hole in the map
		endcase
	end

endmodule

`default_nettype wire

/* ultraSimpleInterface.sv */
`timescale 1ns/10ps
`default_nettype none

`include "usiBus_macros.svh"

module ultraSimpleInterface (
	input wire iUsiClk,
	input wire rst,
	input wire usiBusPkg::usiData mWd,
	input wire usiBusPkg::usiAdrs mAdrs,
	input wire mWCke,
	output wire usiBusPkg::usiData mRd,
	output wire usiBusPkg::usiVd mVd,
	usiIf.bus slv [`USI_SLAVE_NUM]
);
	import usiBusPkg::*;

	usiData rMWd;
	usiAdrs rMAdrs;
	logic rMWCke;
	usiData rRd;
	usiVd rVd;
	usiData slvRd [`USI_SLAVE_NUM];   // Gathered slave words
	usiVd slvVd;
	usiData selRd;
	logic addrVd;                       // Ready of addressed slot
	usiBlock mBlock;

	assign mBlock = mAdrs[`USI_ADRS_BIT-1 -: `USI_BLOCK_BIT];   // Live master block
	assign mRd = rRd;
	assign mVd = rVd;

	// ---------------------------------------------------------------------------
	// Broadcast to every slot
	// ---------------------------------------------------------------------------
	for (genvar g = 0; g < `USI_SLAVE_NUM; g++)
	begin : gSlot
		assign slv[g].wd = rMWd;
		assign slv[g].adrs = rMAdrs;
		assign slv[g].wCke = rMWCke;
		assign slvRd[g] = slv[g].rd;
		assign slvVd[g] = slv[g].vd;
	end

	always_ff @(posedge iUsiClk)
		rMWd <= mWd;    // Write data to every slot

	always_ff @(posedge iUsiClk)
	begin
		if (rst)
		begin
			rMAdrs <= '0;
			rMWCke <= 1'b0;
			rVd <= '0;
			rRd <= '0;
		end
		else
		begin
			rMAdrs <= mAdrs;
			rMWCke <= mWCke;
			rVd <= slvVd;     // Ready back to master
			rRd <= selRd;
		end
	end

	// ---------------------------------------------------------------------------
	// Read select by live block field, slot = block - 1
	// ---------------------------------------------------------------------------
	always_comb
	begin
		selRd = `USI_BAD_ADRS_WORD;     // Unmapped
		addrVd = 1'b1;                  // Nothing to protect when unmapped
		for (int i = 0; i < `USI_SLAVE_NUM; i++)
		begin
			if (mBlock == usiBlock'(i + 1))
			begin
				selRd = slvRd[i];
				addrVd = rVd[i];
			end
		end
	end

	// Master may strobe only into a slot that reports ready at the top
	aStrobeReady : assert property (@(posedge iUsiClk) disable iff (rst) mWCke |-> addrVd)
		else $error("write strobe to block %0d while its slot is not ready", mBlock);

endmodule

`default_nettype wire

/* usiIf.sv */
`timescale 1ns/10ps
`default_nettype none

// ---------------------------------------------------------------------------
// One bus to slave channel
// ---------------------------------------------------------------------------
interface usiIf;
	import usiBusPkg::*;

	usiData wd;     // Write data, registered by the bus
	usiAdrs adrs;   // Block + offset, registered by the bus
	logic wCke;     // One cycle write strobe
	usiData rd;     // Slave word for current offset
	logic vd;       // Slave ready

	modport bus (
		output wd,
		output adrs,
		output wCke,
		input rd,
		input vd
	);

	modport slave (
		input wd,
		input adrs,
		input wCke,
		output rd,
		output vd
	);
endinterface

`default_nettype wire

/* usiCsrPkg.sv */
`default_nettype none

// ---------------------------------------------------------------------------
// Peripheral register map
// ---------------------------------------------------------------------------
package usiCsrPkg;

	// GPIO offsets
	localparam usiBusPkg::usiCsrAdrs GPIO_OUT_OFS = 8'h00;
	localparam usiBusPkg::usiCsrAdrs GPIO_IN_OFS  = 8'h04;
	localparam usiBusPkg::usiCsrAdrs GPIO_ID_OFS  = 8'h08;
	localparam usiBusPkg::usiData GPIO_ID_WORD    = 32'h6B10_0001;   // Fixed ID

	// PWM offsets
	localparam usiBusPkg::usiCsrAdrs PWM_PERIOD_OFS = 8'h00;
	localparam usiBusPkg::usiCsrAdrs PWM_DUTY_OFS   = 8'h04;
	localparam usiBusPkg::usiCsrAdrs PWM_EN_OFS     = 8'h08;
	localparam usiBusPkg::usiCsrAdrs PWM_CNT_OFS    = 8'h0C;   // Read only

	typedef logic [15:0] pwmCount;

	typedef enum logic [1:0] {PWM_IDLE, PWM_RUN, PWM_RELOAD} pwmState;

endpackage

`default_nettype wire

/* usiBusPkg.sv */
`default_nettype none

`include "usiBus_macros.svh"

// ---------------------------------------------------------------------------
// Bus side types
// ---------------------------------------------------------------------------
package usiBusPkg;

	typedef logic [`USI_DATA_BIT-1:0] usiData;     // One bus word
	typedef logic [`USI_ADRS_BIT-1:0] usiAdrs;     // Full address

	// Address fields
	typedef logic [`USI_BLOCK_BIT-1:0] usiBlock;
	typedef logic [`USI_ADRS_BIT-`USI_BLOCK_BIT-1:0] usiCsrAdrs;

	// One ready bit per slot
	typedef logic [`USI_SLAVE_NUM-1:0] usiVd;

endpackage

`default_nettype wire

/* usiBus_macros.svh */
`ifndef USI_BUS_MACROS_SVH
`define USI_BUS_MACROS_SVH

// ---------------------------------------------------------------------------
// Bus geometry
// ---------------------------------------------------------------------------
`define USI_DATA_BIT  32        // Bus word
`define USI_ADRS_BIT  16        // Block + CSR offset
`define USI_BLOCK_BIT 8         // Upper address field

`define USI_SLAVE_NUM 2         // Slots on the bus

// Block map, slot index is block - 1
`define USI_GPIO_MAP  8'h01
`define USI_PWM_MAP   8'h02

// Returned for unmapped blocks, easy to spot in a waveform
`define USI_BAD_ADRS_WORD 32'h1234_5678

`endif
